//--- flist.f
video_rx_pkg.sv
video_word_fifo.sv
video_fifo_rd_ctrl.sv
line_crc_chk.sv
video_rx_regs.sv
video_rx_top.sv
tb_video_rx.sv

//--- Bender.yml
package:
  name: video_rx

sources:
  - video_rx_pkg.sv
  - video_word_fifo.sv
  - video_fifo_rd_ctrl.sv
  - line_crc_chk.sv
  - video_rx_regs.sv
  - video_rx_top.sv
  - target: test
    files:
      - tb_video_rx.sv

//--- tb_video_rx.sv
// video rx testbench: packet traffic, reference crc, forwarded word checks and register access
module tb_video_rx;
   import video_rx_pkg::*;

   localparam int wait_limit = 200;
   localparam int line_limit = 1000;

   logic        fifo_rdclk;
   logic        fifo_rdclk_rst_n;
   logic        wr_en;
   app_word_u   wdata;
   logic        full;
   logic        up_state;
   logic [3:0]  pkt_aggr_id;
   logic        pkt_aggr_id_vld;
   logic        s_axi_awvalid;
   logic [3:0]  s_axi_awaddr;
   logic        s_axi_awready;
   logic        s_axi_wvalid;
   logic [31:0] s_axi_wdata;
   logic [3:0]  s_axi_wstrb;
   logic        s_axi_wready;
   logic        s_axi_bvalid;
   logic [1:0]  s_axi_bresp;
   logic        s_axi_bready;
   logic        s_axi_arvalid;
   logic [3:0]  s_axi_araddr;
   logic        s_axi_arready;
   logic        s_axi_rvalid;
   logic [31:0] s_axi_rdata;
   logic [1:0]  s_axi_rresp;
   logic        s_axi_rready;
   app_word_u   video_data;
   logic        video_data_vld;
   logic        line_end;
   logic        ack;
   logic [3:0]  ack_vld_aggregator;
   logic        sram_lcrc_err;

   app_word_u exp_q[$];
   string     cur_test = "reset";
   int        line_end_cnt = 0;
   int        lcrc_err_cnt = 0;
   int        line_end_mark = 0;
   int        err_mark = 0;
   int        err_model = 0;

   video_rx_top #(
      .fifo_aw (4)
   ) uut (.*);

   always #50 fifo_rdclk = ~fifo_rdclk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic compare(input string name, input logic [139:0] expected,
                          input logic [139:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
      end
   endtask

   // reflected crc-32, one byte at a time, low byte of each beat first
   function automatic logic [31:0] crc32_ref(input logic [127:0] beats [16], input int n_beats);
      logic [31:0] crc;
      logic [7:0]  byte_v;
      crc = crc32_init;
      for (int b = 0; b < n_beats; b++) begin
         for (int k = 0; k < 16; k++) begin
            byte_v = beats[b][8*k +: 8];
            crc = crc ^ {24'd0, byte_v};
            for (int j = 0; j < 8; j++) begin
               crc = crc[0] ? ((crc >> 1) ^ crc32_poly) : (crc >> 1);
            end
         end
      end
      return ~crc;
   endfunction

   function automatic app_word_u data_word(input app_flags_t flags, input logic [127:0] payload);
      app_word_u w;
      w = '0;
      w.dat.flags = flags;
      w.dat.payload = payload;
      return w;
   endfunction

   function automatic app_word_u short_word(input logic [5:0] dt);
      app_word_u w;
      w = '0;
      w.hdr.flags = flag_short;
      w.hdr.short_flag = 1'b1;
      w.hdr.data_type = dt;
      return w;
   endfunction

   // monitor: every forwarded word must be the next expected one
   always @(negedge fifo_rdclk) begin
      if (fifo_rdclk_rst_n) begin
         if (video_data_vld) begin
            if (exp_q.size() == 0) begin
               abort_run($sformatf("%s: word forwarded when none was expected", cur_test));
            end else begin
               compare(cur_test, exp_q.pop_front(), video_data);
            end
         end
         if (line_end) begin
            line_end_cnt++;
         end
         if (sram_lcrc_err) begin
            lcrc_err_cnt++;
         end
      end
   end

   task automatic push_word(input app_word_u w, input bit fwd);
      int n;
      n = 0;
      @(negedge fifo_rdclk);
      while (full && n < wait_limit) begin
         @(negedge fifo_rdclk);
         n++;
      end
      if (full) begin
         abort_run("video fifo stayed full, writer could not continue");
      end
      if (fwd) begin
         exp_q.push_back(w);
      end
      @(posedge fifo_rdclk);
      wr_en <= 1'b1;
      wdata <= w;
      @(posedge fifo_rdclk);
      wr_en <= 1'b0;
   endtask

   task automatic send_long(input int n_beats, input bit with_crc, input bit corrupt);
      app_word_u    w;
      logic [127:0] beats [16];
      logic [31:0]  crc;
      w = '0;
      w.hdr.flags = flag_header;
      w.hdr.data_type = 6'h2A;
      w.hdr.word_count = 16'(n_beats * 16);
      push_word(w, 1'b1);
      for (int i = 0; i < n_beats; i++) begin
         beats[i] = {$urandom, $urandom, $urandom, $urandom};
         push_word(data_word(flag_data, beats[i]), 1'b1);
      end
      push_word(data_word(flag_footer, 128'd0), 1'b1);
      if (with_crc) begin
         crc = crc32_ref(beats, n_beats);
         if (corrupt) begin
            crc = crc ^ 32'h0000_0100;
            err_model++;
         end
         push_word(data_word(flag_crc, {96'd0, crc}), 1'b1);
      end
   endtask

   task automatic start_line(input logic [3:0] id, input logic id_vld);
      logic [3:0] exp_agg;
      int         n;
      @(posedge fifo_rdclk);
      line_end_mark = line_end_cnt;
      err_mark = lcrc_err_cnt;
      pkt_aggr_id <= id;
      pkt_aggr_id_vld <= id_vld;
      up_state <= 1'b1;
      @(posedge fifo_rdclk);
      up_state <= 1'b0;
      n = 0;
      @(negedge fifo_rdclk);
      while (!ack && n < wait_limit) begin
         @(negedge fifo_rdclk);
         n++;
      end
      if (!ack) begin
         abort_run($sformatf("%s: no ack after the up_state request", cur_test));
      end
      exp_agg = 4'b0000;
      if (id_vld && id < 4) begin
         exp_agg[id[1:0]] = 1'b1;
      end
      compare({cur_test, " aggregator"}, exp_agg, ack_vld_aggregator);
      @(negedge fifo_rdclk);
      compare({cur_test, " ack width"}, 0, ack);
   endtask

   task automatic finish_line(input int exp_err_pulses);
      int n;
      n = 0;
      @(negedge fifo_rdclk);
      while (!line_end && n < line_limit) begin
         @(negedge fifo_rdclk);
         n++;
      end
      if (!line_end) begin
         abort_run($sformatf("%s: line_end never came", cur_test));
      end
      repeat (4) @(posedge fifo_rdclk);
      compare({cur_test, " line_end cycles"}, 1, line_end_cnt - line_end_mark);
      compare({cur_test, " crc error pulses"}, exp_err_pulses, lcrc_err_cnt - err_mark);
      compare({cur_test, " words left"}, 0, exp_q.size());
   endtask

   task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
      int n;
      @(posedge fifo_rdclk);
      s_axi_awvalid <= 1'b1;
      s_axi_awaddr <= addr;
      s_axi_wvalid <= 1'b1;
      s_axi_wdata <= data;
      s_axi_wstrb <= 4'hF;
      s_axi_bready <= 1'b1;
      n = 0;
      @(negedge fifo_rdclk);
      while (!s_axi_awready && n < wait_limit) begin
         @(negedge fifo_rdclk);
         n++;
      end
      if (!s_axi_awready) begin
         abort_run("axi write address and data were not accepted");
      end
      compare("axi wready", 1, s_axi_wready);
      @(posedge fifo_rdclk);
      s_axi_awvalid <= 1'b0;
      s_axi_wvalid <= 1'b0;
      n = 0;
      @(negedge fifo_rdclk);
      while (!s_axi_bvalid && n < wait_limit) begin
         @(negedge fifo_rdclk);
         n++;
      end
      if (!s_axi_bvalid) begin
         abort_run("axi write response never arrived");
      end
      compare("axi bresp", 2'b00, s_axi_bresp);
      @(posedge fifo_rdclk);
      s_axi_bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
      int n;
      @(posedge fifo_rdclk);
      s_axi_arvalid <= 1'b1;
      s_axi_araddr <= addr;
      s_axi_rready <= 1'b1;
      n = 0;
      @(negedge fifo_rdclk);
      while (!s_axi_arready && n < wait_limit) begin
         @(negedge fifo_rdclk);
         n++;
      end
      if (!s_axi_arready) begin
         abort_run("axi read address was not accepted");
      end
      @(posedge fifo_rdclk);
      s_axi_arvalid <= 1'b0;
      n = 0;
      @(negedge fifo_rdclk);
      while (!s_axi_rvalid && n < wait_limit) begin
         @(negedge fifo_rdclk);
         n++;
      end
      if (!s_axi_rvalid) begin
         abort_run("axi read data never returned");
      end
      data = s_axi_rdata;
      compare("axi rresp", 2'b00, s_axi_rresp);
      @(posedge fifo_rdclk);
      s_axi_rready <= 1'b0;
   endtask

   // only the low three bits are implemented
   task automatic set_ctrl(input logic [31:0] value);
      logic [31:0] rd;
      axi_write(reg_ctrl_addr, value);
      axi_read(reg_ctrl_addr, rd);
      compare("control readback", value & 32'h7, rd);
   endtask

   task automatic expect_errcnt(input int expected);
      logic [31:0] rd;
      axi_read(reg_errcnt_addr, rd);
      compare({cur_test, " error count"}, expected, rd);
   endtask

   initial begin
      app_word_u w;
      fifo_rdclk = 1'b0;
      fifo_rdclk_rst_n = 1'b0;
      wr_en = 1'b0;
      wdata = '0;
      up_state = 1'b0;
      pkt_aggr_id = 4'd0;
      pkt_aggr_id_vld = 1'b0;
      s_axi_awvalid = 1'b0;
      s_axi_awaddr = 4'd0;
      s_axi_wvalid = 1'b0;
      s_axi_wdata = 32'd0;
      s_axi_wstrb = 4'd0;
      s_axi_bready = 1'b0;
      s_axi_arvalid = 1'b0;
      s_axi_araddr = 4'd0;
      s_axi_rready = 1'b0;
      void'($urandom(66006));
      repeat (5) @(posedge fifo_rdclk);
      fifo_rdclk_rst_n <= 1'b1;
      @(negedge fifo_rdclk);
      compare("reset outputs", 0, {ack, line_end, video_data_vld, sram_lcrc_err, full,
                                   s_axi_awready, s_axi_wready, s_axi_bvalid,
                                   s_axi_arready, s_axi_rvalid});

      cur_test = "ack request";
      start_line(4'd2, 1'b1);

      cur_test = "long packet";
      send_long(4, 1'b1, 1'b0);
      finish_line(0);
      expect_errcnt(err_model);

      // junk in idle ahead of a header
      cur_test = "junk drop";
      push_word(data_word(flag_data, {$urandom, $urandom, $urandom, $urandom}), 1'b0);
      push_word(data_word(flag_footer, 128'd0), 1'b0);
      push_word(data_word(flag_crc, {96'd0, $urandom}), 1'b0);
      push_word(short_word(6'h12), 1'b0);
      send_long(3, 1'b1, 1'b0);
      start_line(4'd0, 1'b1);
      finish_line(0);

      cur_test = "crc error reported";
      set_ctrl(32'h0000_00FA);
      send_long(2, 1'b1, 1'b1);
      start_line(4'd3, 1'b1);
      finish_line(1);
      expect_errcnt(err_model);

      cur_test = "crc error masked";
      set_ctrl(32'h1234_5678);
      send_long(5, 1'b1, 1'b1);
      start_line(4'd7, 1'b1);
      finish_line(0);
      expect_errcnt(err_model);
      axi_write(reg_errcnt_addr, 32'd0);
      err_model = 0;
      expect_errcnt(err_model);

      // footer ends the line, the short packet waits for the next one
      cur_test = "crc disabled";
      set_ctrl(32'hA5A5_A5A5);
      send_long(2, 1'b0, 1'b0);
      w = short_word(csi_line_start);
      push_word(w, 1'b0);
      start_line(4'd1, 1'b0);
      finish_line(0);

      cur_test = "short with line end";
      exp_q.push_back(w);
      start_line(4'd2, 1'b1);
      finish_line(0);

      cur_test = "short without line end";
      set_ctrl(32'h1234_5678);
      push_word(short_word(csi_line_start), 1'b1);
      send_long(3, 1'b1, 1'b0);
      start_line(4'd1, 1'b1);
      finish_line(0);
      expect_errcnt(err_model);

      cur_test = "end of run";
      repeat (5) @(posedge fifo_rdclk);
      if (exp_q.size() != 0) begin
         abort_run("words were expected on video_data but never came out");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

//--- video_rx_top.sv
// video rx top: word fifo, read controller, line crc checker and register slave
module video_rx_top #(
   parameter int fifo_aw = 4
) (
   input  logic                    fifo_rdclk,
   input  logic                    fifo_rdclk_rst_n,
   input  logic                    wr_en,
   input  video_rx_pkg::app_word_u wdata,
   output logic                    full,
   input  logic                    up_state,
   input  logic [3:0]              pkt_aggr_id,
   input  logic                    pkt_aggr_id_vld,
   input  logic                    s_axi_awvalid,
   input  logic [3:0]              s_axi_awaddr,
   output logic                    s_axi_awready,
   input  logic                    s_axi_wvalid,
   input  logic [31:0]             s_axi_wdata,
   input  logic [3:0]              s_axi_wstrb,
   output logic                    s_axi_wready,
   output logic                    s_axi_bvalid,
   output logic [1:0]              s_axi_bresp,
   input  logic                    s_axi_bready,
   input  logic                    s_axi_arvalid,
   input  logic [3:0]              s_axi_araddr,
   output logic                    s_axi_arready,
   output logic                    s_axi_rvalid,
   output logic [31:0]             s_axi_rdata,
   output logic [1:0]              s_axi_rresp,
   input  logic                    s_axi_rready,
   output video_rx_pkg::app_word_u video_data,
   output logic                    video_data_vld,
   output logic                    line_end,
   output logic                    ack,
   output logic [3:0]              ack_vld_aggregator,
   output logic                    sram_lcrc_err
);
   import video_rx_pkg::*;

   app_word_u video_data_fifo_rdata;
   logic      video_data_fifo_empty;
   logic      video_data_fifo_rd;
   rx_state_e current_state;
   logic      video_crc_err;
   logic      crc_gen_dis;
   logic      lcrc_err_oen;
   logic      empty_depend_mux;

   video_word_fifo #(
      .fifo_aw (fifo_aw)
   ) u_fifo (
      .fifo_rdclk,
      .fifo_rdclk_rst_n,
      .wr_en,
      .wdata,
      .rd    (video_data_fifo_rd),
      .rdata (video_data_fifo_rdata),
      .empty (video_data_fifo_empty),
      .full
   );

   video_fifo_rd_ctrl u_rd_ctrl (
      .fifo_rdclk,
      .fifo_rdclk_rst_n,
      .up_state,
      .video_data_fifo_empty,
      .video_data_fifo_rdata,
      .empty_depend_mux,
      .pkt_aggr_id,
      .pkt_aggr_id_vld,
      .crc_gen_dis,
      .lcrc_err_oen,
      .video_crc_err,
      .ack,
      .line_end,
      .video_data_fifo_rd,
      .video_data,
      .video_data_vld,
      .current_state,
      .ack_vld_aggregator,
      .sram_lcrc_err
   );

   line_crc_chk u_crc_chk (
      .fifo_rdclk,
      .fifo_rdclk_rst_n,
      .video_data_vld,
      .video_data,
      .current_state,
      .video_crc_err
   );

   video_rx_regs u_regs (
      .fifo_rdclk,
      .fifo_rdclk_rst_n,
      .awvalid          (s_axi_awvalid),
      .awaddr           (s_axi_awaddr),
      .wvalid           (s_axi_wvalid),
      .wdata            (s_axi_wdata),
      .wstrb            (s_axi_wstrb),
      .bready           (s_axi_bready),
      .arvalid          (s_axi_arvalid),
      .araddr           (s_axi_araddr),
      .rready           (s_axi_rready),
      .video_crc_err,
      .awready          (s_axi_awready),
      .wready           (s_axi_wready),
      .bvalid           (s_axi_bvalid),
      .bresp            (s_axi_bresp),
      .arready          (s_axi_arready),
      .rvalid           (s_axi_rvalid),
      .rdata            (s_axi_rdata),
      .rresp            (s_axi_rresp),
      .crc_gen_dis,
      .lcrc_err_oen,
      .empty_depend_mux
   );

endmodule

//--- video_rx_regs.sv
// video rx registers: axi4-lite slave for control bits and the line crc error count
module video_rx_regs (
   input  logic        fifo_rdclk,
   input  logic        fifo_rdclk_rst_n,
   input  logic        awvalid,
   input  logic [3:0]  awaddr,
   input  logic        wvalid,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        bready,
   input  logic        arvalid,
   input  logic [3:0]  araddr,
   input  logic        rready,
   input  logic        video_crc_err,
   output logic        awready,
   output logic        wready,
   output logic        bvalid,
   output logic [1:0]  bresp,
   output logic        arready,
   output logic        rvalid,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        crc_gen_dis,
   output logic        lcrc_err_oen,
   output logic        empty_depend_mux
);
   import video_rx_pkg::*;

   logic        wr_hs;
   logic        wr_acc;
   logic        rd_hs;
   logic [2:0]  ctrl_q;
   logic [15:0] err_cnt;

   // address and data taken together
   assign wr_hs  = awvalid && wvalid && !awready && !bvalid;
   assign wr_acc = awready && awvalid && wvalid;
   assign rd_hs  = arvalid && !arready && !rvalid;

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         ctrl_q  <= 3'b000;
         err_cnt <= 16'd0;
      end else begin
         awready <= wr_hs;
         wready  <= wr_hs;
         arready <= rd_hs;
         if (wr_acc) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (arready) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
         if (wr_acc && (awaddr == reg_ctrl_addr) && wstrb[0]) begin
            ctrl_q <= wdata[2:0];
         end
         // any write clears, saturates otherwise
         if (wr_acc && (awaddr == reg_errcnt_addr)) begin
            err_cnt <= 16'd0;
         end else if (video_crc_err && (err_cnt != 16'hFFFF)) begin
            err_cnt <= err_cnt + 16'd1;
         end
      end
   end

   always_ff @(posedge fifo_rdclk) begin
      if (rd_hs) begin
         case (araddr)
            reg_ctrl_addr:   rdata <= {29'd0, ctrl_q};
            reg_errcnt_addr: rdata <= {16'd0, err_cnt};
            default:         rdata <= 32'd0;
         endcase
      end
   end

   assign bresp = 2'b00;
   assign rresp = 2'b00;

   assign crc_gen_dis      = ctrl_q[0];
   assign lcrc_err_oen     = ctrl_q[1];
   assign empty_depend_mux = ctrl_q[2];

endmodule

//--- line_crc_chk.sv
// line crc checker: crc-32 over forwarded payload beats, checked against the line crc word
module line_crc_chk (
   input  logic                    fifo_rdclk,
   input  logic                    fifo_rdclk_rst_n,
   input  logic                    video_data_vld,
   input  video_rx_pkg::app_word_u video_data,
   input  video_rx_pkg::rx_state_e current_state,
   output logic                    video_crc_err
);
   import video_rx_pkg::*;

   logic [31:0] crc_acc;
   logic        crc_word;

   // bitwise reflected crc, low byte first, lsb first within a byte
   function automatic logic [31:0] crc32_fold(input logic [31:0] crc_in,
                                              input logic [127:0] beat);
      logic [31:0] c;
      c = crc_in;
      for (int i = 0; i < 128; i++) begin
         if (c[0] ^ beat[i]) begin
            c = (c >> 1) ^ crc32_poly;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   assign crc_word = video_data_vld && (current_state == rx_line_crc);

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         crc_acc       <= crc32_init;
         video_crc_err <= 1'b0;
      end else begin
         if (video_data_vld && (video_data.hdr.flags == flag_header)) begin
            crc_acc <= crc32_init;
         end else if (video_data_vld && (video_data.dat.flags == flag_data)) begin
            crc_acc <= crc32_fold(crc_acc, video_data.dat.payload);
         end
         // final value is the inverted accumulator
         video_crc_err <= crc_word && (video_data.dat.payload[31:0] != ~crc_acc);
      end
   end

   // controller enters line_crc only on a crc word
   a_crc_word_flags : assert property (@(posedge fifo_rdclk) disable iff (!fifo_rdclk_rst_n)
      crc_word |-> (video_data.dat.flags == flag_crc))
      else $error("word checked as line crc carries packet flags");

endmodule

//--- video_fifo_rd_ctrl.sv
// video fifo read controller: packet fsm, fifo pop, junk drop, video output and ack
module video_fifo_rd_ctrl (
   input  logic                    fifo_rdclk,
   input  logic                    fifo_rdclk_rst_n,
   input  logic                    up_state,
   input  logic                    video_data_fifo_empty,
   input  video_rx_pkg::app_word_u video_data_fifo_rdata,
   input  logic                    empty_depend_mux,
   input  logic [3:0]              pkt_aggr_id,
   input  logic                    pkt_aggr_id_vld,
   input  logic                    crc_gen_dis,
   input  logic                    lcrc_err_oen,
   input  logic                    video_crc_err,
   output logic                    ack,
   output logic                    line_end,
   output logic                    video_data_fifo_rd,
   output video_rx_pkg::app_word_u video_data,
   output logic                    video_data_vld,
   output video_rx_pkg::rx_state_e current_state,
   output logic [3:0]              ack_vld_aggregator,
   output logic                    sram_lcrc_err
);
   import video_rx_pkg::*;

   rx_state_e next_state;
   logic      empty;
   logic      is_short;
   logic      is_header;
   logic      is_footer;
   logic      is_payload;
   logic      is_crc;
   logic      junk_rd;
   logic      fwd_rd;

   assign empty = video_data_fifo_empty;

   // short packets limited to frame and line start/end
   assign is_short   = (video_data_fifo_rdata.hdr.flags == flag_short) &&
                       (video_data_fifo_rdata.hdr.data_type inside
                        {csi_frame_start, csi_frame_end, csi_line_start, csi_line_end});
   assign is_header  = (video_data_fifo_rdata.hdr.flags == flag_header);
   assign is_footer  = (video_data_fifo_rdata.dat.flags == flag_footer);
   assign is_payload = (video_data_fifo_rdata.dat.flags == flag_data);
   assign is_crc     = (video_data_fifo_rdata.dat.flags == flag_crc);

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         current_state <= rx_silent;
      end else begin
         current_state <= next_state;
      end
   end

   always_comb begin
      next_state = current_state;
      case (current_state)
         rx_silent: begin
            if (up_state) begin
               next_state = rx_idle;
            end
         end
         rx_idle: begin
            if (!empty && is_short) begin
               next_state = rx_short;
            end else if (!empty && is_header) begin
               next_state = rx_header;
            end
         end
         rx_short: begin
            next_state = empty_depend_mux ? rx_line_end : rx_idle;
         end
         rx_header, rx_data: begin
            if (empty) begin
               next_state = rx_data;
            end else if (is_footer) begin
               next_state = rx_footer;
            end else if (is_payload) begin
               next_state = rx_data;
            end else begin
               next_state = rx_idle;
            end
         end
         rx_footer: begin
            if (crc_gen_dis) begin
               next_state = rx_line_end;
            end else if (!empty) begin
               next_state = is_crc ? rx_line_crc : rx_idle;
            end
         end
         rx_line_crc: next_state = rx_line_end;
         rx_line_end: next_state = rx_silent;
         default:     next_state = rx_silent;
      endcase
   end

   // anything in idle that does not open a packet is dropped
   assign junk_rd = (current_state == rx_idle) && !empty && !is_short && !is_header;
   assign fwd_rd  = !empty &&
                    (next_state inside {rx_short, rx_header, rx_data, rx_footer, rx_line_crc});
   assign video_data_fifo_rd = fwd_rd || junk_rd;

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         video_data_vld <= 1'b0;
         ack            <= 1'b0;
      end else begin
         video_data_vld <= fwd_rd;
         ack            <= (current_state == rx_silent) && up_state;
      end
   end

   always_ff @(posedge fifo_rdclk) begin
      if (fwd_rd) begin
         video_data <= video_data_fifo_rdata;
      end
   end

   assign line_end      = (current_state == rx_line_end);
   assign sram_lcrc_err = lcrc_err_oen && video_crc_err;

   // steer ack to one of four aggregators
   always_comb begin
      ack_vld_aggregator = 4'b0000;
      if (ack && pkt_aggr_id_vld && (pkt_aggr_id < 4'd4)) begin
         ack_vld_aggregator[pkt_aggr_id[1:0]] = 1'b1;
      end
   end

   // head word must hold while it waits to be popped
   a_head_stable : assert property (@(posedge fifo_rdclk) disable iff (!fifo_rdclk_rst_n)
      !video_data_fifo_empty && !video_data_fifo_rd |=> $stable(video_data_fifo_rdata))
      else $error("fifo head word changed without a pop");

endmodule

//--- video_word_fifo.sv
// video word fifo: single-clock first-word-fall-through buffer for video words
module video_word_fifo #(
   parameter int fifo_aw = 4
) (
   input  logic                    fifo_rdclk,
   input  logic                    fifo_rdclk_rst_n,
   input  logic                    wr_en,
   input  video_rx_pkg::app_word_u wdata,
   input  logic                    rd,
   output video_rx_pkg::app_word_u rdata,
   output logic                    empty,
   output logic                    full
);
   import video_rx_pkg::*;

   localparam int depth = 1 << fifo_aw;

   app_word_u        mem [depth];
   logic [fifo_aw:0] wr_ptr;
   logic [fifo_aw:0] rd_ptr;

   // extra msb tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw]) &&
                  (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);

   // head word shown without a read
   assign rdata = mem[rd_ptr[fifo_aw-1:0]];

   always_ff @(posedge fifo_rdclk) begin
      if (wr_en && !full) begin
         mem[wr_ptr[fifo_aw-1:0]] <= wdata;
      end
   end

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd && !empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   a_no_overflow : assert property (@(posedge fifo_rdclk) disable iff (!fifo_rdclk_rst_n)
      wr_en |-> !full) else $error("video fifo written while full");

   a_no_underflow : assert property (@(posedge fifo_rdclk) disable iff (!fifo_rdclk_rst_n)
      rd |-> !empty) else $error("video fifo read while empty");

endmodule

//--- video_rx_pkg.sv
// video rx package: word layout, flag encodings, fsm states, crc and register constants
package video_rx_pkg;

   localparam int video_word_w = 140;

   // flags occupy word bits 135:132
   typedef struct packed {
      logic data_en;
      logic short_en;
      logic footer_en;
      logic header_en;
   } app_flags_t;

   localparam app_flags_t flag_short  = 4'b0100;
   localparam app_flags_t flag_header = 4'b0001;
   localparam app_flags_t flag_data   = 4'b1000;
   localparam app_flags_t flag_footer = 4'b0010;
   localparam app_flags_t flag_crc    = 4'b0000;

   typedef struct packed {
      logic [3:0]               spare;
      app_flags_t               flags;
      logic                     short_flag;
      logic [5:0]               data_type;
      logic [15:0]              word_count;
      logic [video_word_w-32:0] pad;
   } app_header_t;

   // line crc word carries its crc in payload[31:0]
   typedef struct packed {
      logic [3:0]   spare;
      app_flags_t   flags;
      logic [3:0]   pad;
      logic [127:0] payload;
   } app_data_t;

   typedef union packed {
      app_header_t hdr;
      app_data_t   dat;
   } app_word_u;

   localparam logic [5:0] csi_frame_start = 6'h00;
   localparam logic [5:0] csi_frame_end   = 6'h01;
   localparam logic [5:0] csi_line_start  = 6'h02;
   localparam logic [5:0] csi_line_end    = 6'h03;

   typedef enum logic [2:0] {
      rx_silent   = 3'd0,
      rx_idle     = 3'd1,
      rx_short    = 3'd2,
      rx_header   = 3'd3,
      rx_data     = 3'd4,
      rx_footer   = 3'd5,
      rx_line_crc = 3'd6,
      rx_line_end = 3'd7
   } rx_state_e;

   // reflected ieee polynomial, init all ones, final inversion
   localparam logic [31:0] crc32_poly = 32'hEDB8_8320;
   localparam logic [31:0] crc32_init = 32'hFFFF_FFFF;

   localparam logic [3:0] reg_ctrl_addr   = 4'h0;
   localparam logic [3:0] reg_errcnt_addr = 4'h4;

endpackage
